/* source/rename_pkg.sv */
package rename_pkg;

  // ******************************
  // sizes
  // ******************************
  localparam int XLEN        = 32;
  localparam int ARCH_REGS   = 32;
  localparam int PHYS_REGS   = 64;
  localparam int PREG_W      = 6;
  localparam int ARCH_W      = 5;
  localparam int ISSUE_WIDTH = 2;
  localparam int FREE_DEPTH  = 32;
  localparam int FREE_W      = 5;

  // rv32 major opcodes the decoder cares about
  localparam logic [6:0] OP_R      = 7'b0110011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  // ******************************
  // instruction word views
  // ******************************
  typedef struct packed {
    logic [6:0]        funct7;
    logic [ARCH_W-1:0] rs2;
    logic [ARCH_W-1:0] rs1;
    logic [2:0]        funct3;
    logic [ARCH_W-1:0] rd;
    logic [6:0]        opcode;
  } r_fields_t;

  typedef struct packed {
    logic [11:0]       imm12;
    logic [ARCH_W-1:0] rs1;
    logic [2:0]        funct3;
    logic [ARCH_W-1:0] rd;
    logic [6:0]        opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_fields;
    i_fields_t i_fields;
  } instr_word_u;

  typedef struct packed {
    logic              valid;
    logic [ARCH_W-1:0] rd;   // zero when nothing is written
    logic [ARCH_W-1:0] rs1;
    logic [ARCH_W-1:0] rs2;
    logic              uses_rs2;
    logic [11:0]       imm12;
    logic [6:0]        opcode;
    logic              spec;
  } slot_req_t;

  typedef struct packed {
    logic              rename;
    logic [ARCH_W-1:0] rd;
    logic              spec;
    logic [ARCH_W-1:0] src_1;
    logic [ARCH_W-1:0] src_2;
  } reg_query_t;

  typedef struct packed {
    logic [PREG_W-1:0] rn;
    logic [XLEN-1:0]   data_1;
    logic              valid_1;
    logic [PREG_W-1:0] rrn_1;
    logic [XLEN-1:0]   data_2;
    logic              valid_2;
    logic [PREG_W-1:0] rrn_2;
  } reg_answer_t;

  typedef struct packed {
    logic [XLEN-1:0]   value;
    logic [PREG_W-1:0] tag;
    logic              ready;
  } operand_t;

  typedef struct packed {
    logic              valid;
    logic [ARCH_W-1:0] rd;
    logic [PREG_W-1:0] rn;
    logic [6:0]        opcode;
    logic [11:0]       imm12;
    operand_t          src_1;
    operand_t          src_2;
    logic [ARCH_W-1:0] rs1;
    logic [ARCH_W-1:0] rs2;
  } lane_out_t;

  typedef struct packed {
    logic              valid;
    logic [ARCH_W-1:0] arn;  // 0 means execution result
    logic [PREG_W-1:0] rrn;
    logic [XLEN-1:0]   result;
  } wb_port_t;

  typedef struct packed {
    logic              valid;
    logic [PREG_W-1:0] rn;
    logic [6:0]        opcode;
    logic [11:0]       imm12;
    operand_t          src_1;
    operand_t          src_2;
  } dispatch_slot_t;

endpackage

/* source/bundle_decoder.sv */
`timescale 1ns/100ps

module bundle_decoder
  import rename_pkg::*;
(
  input  logic        global_bus,
  input  logic        rst_n,
  input  instr_word_u bundle_in [ISSUE_WIDTH],
  input  logic        bundle_valid,
  input  logic        bundle_spec,
  input  logic        can_accept,
  input  logic        rename_ok,
  output logic        bundle_ready,
  output slot_req_t   slot_req [ISSUE_WIDTH]
);

  logic live_q;
  logic accept;

  // no bundles during the first cycle out of reset
  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  assign bundle_ready = live_q && can_accept && rename_ok;
  assign accept       = bundle_valid && bundle_ready;

  // ******************************
  // per-slot field decode
  // ******************************
  always_comb begin : decode
    instr_word_u word;
    logic [6:0]  opc;
    logic        writes_rd;
    logic        uses_rs2;
    logic        no_rs1;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      word      = bundle_in[i];
      opc       = word.r_fields.opcode;
      writes_rd = !(opc == OP_STORE || opc == OP_BRANCH);
      uses_rs2  = (opc == OP_R) || (opc == OP_STORE) || (opc == OP_BRANCH);
      no_rs1    = (opc == OP_LUI) || (opc == OP_AUIPC) || (opc == OP_JAL);

      slot_req[i].valid    = accept;  // lanes never recheck acceptance
      slot_req[i].rd       = writes_rd ? word.r_fields.rd : '0;
      slot_req[i].rs1      = no_rs1 ? '0 : word.i_fields.rs1;
      slot_req[i].rs2      = uses_rs2 ? word.r_fields.rs2 : '0;
      slot_req[i].uses_rs2 = uses_rs2;
      slot_req[i].imm12    = word.i_fields.imm12;  // other view of the same bits
      slot_req[i].opcode   = opc;
      slot_req[i].spec     = bundle_spec;
    end
  end

endmodule

/* source/operand_lane.sv */
`timescale 1ns/100ps

module operand_lane
  import rename_pkg::*;
(
  input  logic        global_bus,
  input  logic        rst_n,
  input  slot_req_t   slot_req,
  input  reg_answer_t reg_answer,
  input  logic        lane_hold,
  output reg_query_t  reg_query,
  output lane_out_t   lane_out
);

  lane_out_t         lane_next;
  logic [ARCH_W-1:0] src_2;

  function automatic operand_t resolve(input logic [ARCH_W-1:0] src,
                                       input logic [XLEN-1:0]   data,
                                       input logic              valid,
                                       input logic [PREG_W-1:0] rrn);
    operand_t op;
    op = '{value: '0, tag: '0, ready: 1'b1};  // x0 and unused read as zero
    if (src != '0) begin
      if (valid) begin
        op.value = data;
      end else begin
        op.tag   = rrn;
        op.ready = 1'b0;
      end
    end
    return op;
  endfunction

  assign src_2 = slot_req.uses_rs2 ? slot_req.rs2 : '0;

  assign reg_query.rename = slot_req.valid && (slot_req.rd != '0);
  assign reg_query.rd     = slot_req.rd;
  assign reg_query.spec   = slot_req.spec;
  assign reg_query.src_1  = slot_req.rs1;
  assign reg_query.src_2  = src_2;

  always_comb begin
    lane_next.valid  = slot_req.valid;
    lane_next.rd     = reg_query.rename ? slot_req.rd : '0;
    lane_next.rn     = reg_answer.rn;
    lane_next.opcode = slot_req.opcode;
    lane_next.imm12  = slot_req.imm12;
    lane_next.src_1  = resolve(slot_req.rs1, reg_answer.data_1, reg_answer.valid_1,
                               reg_answer.rrn_1);
    lane_next.src_2  = resolve(src_2, reg_answer.data_2, reg_answer.valid_2,
                               reg_answer.rrn_2);
    lane_next.rs1    = slot_req.rs1;
    lane_next.rs2    = src_2;
  end

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      lane_out.valid <= 1'b0;
    end else if (!lane_hold) begin
      lane_out <= lane_next;
    end
  end

endmodule

/* source/register_file.sv */
`timescale 1ns/100ps

module register_file
  import rename_pkg::*;
(
  input  logic        global_bus,
  input  logic        rst_n,
  input  reg_query_t  reg_query [ISSUE_WIDTH],
  output reg_answer_t reg_answer [ISSUE_WIDTH],
  input  wb_port_t    wb [ISSUE_WIDTH],
  input  logic        spec_clear,
  input  logic        spec_flush,
  output logic        rename_ok
);

  typedef struct packed {
    logic [XLEN-1:0]   value;
    logic [PREG_W-1:0] rrn;
    logic              valid;
    logic              tag;
  } reg_entry_t;

  reg_entry_t        regs [PHYS_REGS];
  logic [PREG_W-1:0] free_list [FREE_DEPTH];
  logic [FREE_W-1:0] head;
  logic [FREE_W-1:0] tail;
  logic [FREE_W:0]   free_count;
  logic [FREE_W-1:0] alloc_ptr [ISSUE_WIDTH+1];
  logic [PREG_W-1:0] alloc_rn [ISSUE_WIDTH];

  assign rename_ok = (free_count >= (FREE_W+1)'(ISSUE_WIDTH));

  // ******************************
  // allocation and read answer
  // ******************************
  always_comb begin
    alloc_ptr[0] = head;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      alloc_ptr[i+1] = alloc_ptr[i] + FREE_W'(reg_query[i].rename);  // lane 1 after lane 0
      alloc_rn[i]    = free_list[alloc_ptr[i]];

      reg_answer[i].rn      = reg_query[i].rename ? alloc_rn[i] : '0;
      reg_answer[i].data_1  = regs[{1'b0, reg_query[i].src_1}].value;
      reg_answer[i].valid_1 = regs[{1'b0, reg_query[i].src_1}].valid;
      reg_answer[i].rrn_1   = regs[{1'b0, reg_query[i].src_1}].rrn;
      reg_answer[i].data_2  = regs[{1'b0, reg_query[i].src_2}].value;
      reg_answer[i].valid_2 = regs[{1'b0, reg_query[i].src_2}].valid;
      reg_answer[i].rrn_2   = regs[{1'b0, reg_query[i].src_2}].rrn;
    end
  end

  // ******************************
  // state update
  // ******************************
  always_ff @(posedge global_bus) begin : update
    logic [FREE_W-1:0] tail_v;
    logic [FREE_W:0]   count_v;
    logic [PREG_W-1:0] arn;
    if (!rst_n) begin
      for (int j = 0; j < PHYS_REGS; j++) begin
        regs[j] <= '{value: '0, rrn: '0, valid: (j < ARCH_REGS), tag: 1'b0};
      end
      for (int j = 0; j < FREE_DEPTH; j++) begin
        free_list[j] <= PREG_W'(ARCH_REGS + j);  // ascending
      end
      head       <= '0;
      tail       <= '0;
      free_count <= (FREE_W+1)'(FREE_DEPTH);
    end else begin
      tail_v  = tail;
      count_v = free_count;

      // write-back first so a same-edge rename wins the entry
      for (int i = 0; i < ISSUE_WIDTH; i++) begin
        if (wb[i].valid) begin
          if (wb[i].arn == '0) begin
            regs[wb[i].rrn].value <= wb[i].result;  // execution result
            regs[wb[i].rrn].valid <= 1'b1;
          end else begin
            arn = {1'b0, wb[i].arn};
            regs[arn].value <= wb[i].result;
            if (regs[arn].rrn == wb[i].rrn) begin  // not renamed again
              regs[arn].valid <= 1'b1;
              regs[arn].tag   <= 1'b0;
              regs[arn].rrn   <= '0;
            end
            regs[wb[i].rrn]   <= '0;
            free_list[tail_v] <= wb[i].rrn;
            tail_v            = tail_v + 1'b1;
            count_v           = count_v + 1'b1;
          end
        end
      end

      for (int i = 0; i < ISSUE_WIDTH; i++) begin
        if (reg_query[i].rename) begin
          regs[{1'b0, reg_query[i].rd}].rrn   <= alloc_rn[i];
          regs[{1'b0, reg_query[i].rd}].valid <= 1'b0;
          regs[{1'b0, reg_query[i].rd}].tag   <= reg_query[i].spec;
          regs[alloc_rn[i]] <= '{value: '0, rrn: '0, valid: 1'b0, tag: reg_query[i].spec};
          count_v = count_v - 1'b1;
        end
      end
      head <= alloc_ptr[ISSUE_WIDTH];

      if (spec_clear) begin
        for (int j = 0; j < PHYS_REGS; j++) begin
          regs[j].tag <= 1'b0;
        end
      end

      if (spec_flush) begin
        for (int j = 0; j < ARCH_REGS; j++) begin
          if (regs[j].tag) begin
            regs[j].tag   <= 1'b0;
            regs[j].rrn   <= '0;
            regs[j].valid <= 1'b1;  // back to the committed value
          end
        end
        for (int j = ARCH_REGS; j < PHYS_REGS; j++) begin
          if (regs[j].tag) begin
            regs[j]           <= '0;
            free_list[tail_v] <= PREG_W'(j);
            tail_v            = tail_v + 1'b1;
            count_v           = count_v + 1'b1;
          end
        end
      end

      tail       <= tail_v;
      free_count <= count_v;
    end
  end

endmodule

/* source/dispatch_merger.sv */
`timescale 1ns/100ps

module dispatch_merger
  import rename_pkg::*;
(
  input  logic           global_bus,
  input  logic           rst_n,
  input  lane_out_t      lane_out [ISSUE_WIDTH],
  input  logic           dispatch_ready,
  output logic           lane_hold,
  output logic           can_accept,
  output dispatch_slot_t dispatch [ISSUE_WIDTH],
  output logic           dispatch_valid
);

  logic           held_valid_q;

  // ******************************
  // intra-bundle dependency fix
  // ******************************
  always_comb begin
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      dispatch[i].valid  = lane_out[i].valid;
      dispatch[i].rn     = lane_out[i].rn;
      dispatch[i].opcode = lane_out[i].opcode;
      dispatch[i].imm12  = lane_out[i].imm12;
      dispatch[i].src_1  = lane_out[i].src_1;
      dispatch[i].src_2  = lane_out[i].src_2;
      for (int k = 0; k < i; k++) begin  // nearest older slot wins
        if (lane_out[k].rd != '0 && lane_out[i].rs1 == lane_out[k].rd) begin
          dispatch[i].src_1 = '{value: '0, tag: lane_out[k].rn, ready: 1'b0};
        end
        if (lane_out[k].rd != '0 && lane_out[i].rs2 == lane_out[k].rd) begin
          dispatch[i].src_2 = '{value: '0, tag: lane_out[k].rn, ready: 1'b0};
        end
      end
    end
  end

  assign dispatch_valid = held_valid_q || lane_out[0].valid;
  assign lane_hold      = dispatch_valid && !dispatch_ready;
  assign can_accept     = !dispatch_valid || dispatch_ready;

  always_ff @(posedge global_bus) begin
    if (!rst_n) begin
      held_valid_q <= 1'b0;
    end else begin
      held_valid_q <= lane_hold;  // drops on the transfer edge
    end
  end

endmodule

/* source/rename_unit.sv */
`timescale 1ns/100ps

module rename_unit
  import rename_pkg::*;
(
  input  logic           global_bus,
  input  logic           rst_n,
  input  instr_word_u    bundle_in [ISSUE_WIDTH],
  input  logic           bundle_valid,
  input  logic           bundle_spec,
  output logic           bundle_ready,
  input  wb_port_t       wb [ISSUE_WIDTH],
  input  logic           spec_clear,
  input  logic           spec_flush,
  output dispatch_slot_t dispatch [ISSUE_WIDTH],
  output logic           dispatch_valid,
  input  logic           dispatch_ready
);

  slot_req_t   slot_req [ISSUE_WIDTH];
  reg_query_t  reg_query [ISSUE_WIDTH];
  reg_answer_t reg_answer [ISSUE_WIDTH];
  lane_out_t   lane_out [ISSUE_WIDTH];
  logic        lane_hold;
  logic        can_accept;
  logic        rename_ok;

  bundle_decoder u_decoder (
    .global_bus   (global_bus),
    .rst_n        (rst_n),
    .bundle_in    (bundle_in),
    .bundle_valid (bundle_valid),
    .bundle_spec  (bundle_spec),
    .can_accept   (can_accept),
    .rename_ok    (rename_ok),
    .bundle_ready (bundle_ready),
    .slot_req     (slot_req)
  );

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : gen_lane
    operand_lane u_lane (
      .global_bus (global_bus),
      .rst_n      (rst_n),
      .slot_req   (slot_req[i]),
      .reg_answer (reg_answer[i]),
      .lane_hold  (lane_hold),
      .reg_query  (reg_query[i]),
      .lane_out   (lane_out[i])
    );
  end

  register_file u_regfile (
    .global_bus (global_bus),
    .rst_n      (rst_n),
    .reg_query  (reg_query),
    .reg_answer (reg_answer),
    .wb         (wb),
    .spec_clear (spec_clear),
    .spec_flush (spec_flush),
    .rename_ok  (rename_ok)
  );

  dispatch_merger u_merger (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .lane_out       (lane_out),
    .dispatch_ready (dispatch_ready),
    .lane_hold      (lane_hold),
    .can_accept     (can_accept),
    .dispatch       (dispatch),
    .dispatch_valid (dispatch_valid)
  );

endmodule

/* verification/rename_unit_tb.sv */
`timescale 1ns/100ps

module rename_unit_tb
  import rename_pkg::*;
();

  localparam int TIMEOUT = 50;
  localparam int SETTLE  = 3;  // sample point after the falling edge

  logic           global_bus;
  logic           rst_n;
  instr_word_u    bundle_in [ISSUE_WIDTH];
  logic           bundle_valid;
  logic           bundle_spec;
  logic           bundle_ready;
  wb_port_t       wb [ISSUE_WIDTH];
  logic           spec_clear;
  logic           spec_flush;
  dispatch_slot_t dispatch [ISSUE_WIDTH];
  logic           dispatch_valid;
  logic           dispatch_ready;

  dispatch_slot_t expected_q [$];  // two slots per accepted bundle
  logic [31:0]    field [13];      // tokens of the current stimulus line
  logic           stall_on;
  logic [31:0]    lfsr;
  int             idle_cycles;

  rename_unit UUT (
    .global_bus     (global_bus),
    .rst_n          (rst_n),
    .bundle_in      (bundle_in),
    .bundle_valid   (bundle_valid),
    .bundle_spec    (bundle_spec),
    .bundle_ready   (bundle_ready),
    .wb             (wb),
    .spec_clear     (spec_clear),
    .spec_flush     (spec_flush),
    .dispatch       (dispatch),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready)
  );

  always #4 global_bus = ~global_bus;

  // ******************************
  // error reporting and compares
  // ******************************
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_value(name, 64'(got), 64'(exp));
    end
  endtask

  task automatic check_operand(input string name, input operand_t got, input operand_t exp);
    if (got.ready !== exp.ready) begin
      report_value({name, ".ready"}, 64'(got.ready), 64'(exp.ready));
    end else if (exp.ready && got.value !== exp.value) begin
      report_value({name, ".value"}, 64'(got.value), 64'(exp.value));
    end else if (!exp.ready && got.tag !== exp.tag) begin
      report_value({name, ".tag"}, 64'(got.tag), 64'(exp.tag));
    end
  endtask

  task automatic check_slot(input string name, input dispatch_slot_t got,
                            input dispatch_slot_t exp);
    if (got.valid !== exp.valid) begin
      report_value({name, ".valid"}, 64'(got.valid), 64'(exp.valid));
    end else if (got.rn !== exp.rn) begin
      report_value({name, ".rn"}, 64'(got.rn), 64'(exp.rn));
    end else if (got.opcode !== exp.opcode) begin
      report_value({name, ".opcode"}, 64'(got.opcode), 64'(exp.opcode));
    end else if (got.imm12 !== exp.imm12) begin
      report_value({name, ".imm12"}, 64'(got.imm12), 64'(exp.imm12));
    end
    check_operand({name, ".src_1"}, got.src_1, exp.src_1);
    check_operand({name, ".src_2"}, got.src_2, exp.src_2);
  endtask

  // ready operands carry data, waiting ones carry the producer tag
  function automatic operand_t expect_operand(input logic [31:0] rdy, input logic [31:0] val);
    operand_t op;
    op       = '0;
    op.ready = rdy[0];
    if (rdy[0]) begin
      op.value = val;
    end else begin
      op.tag = val[PREG_W-1:0];
    end
    return op;
  endfunction

  function automatic dispatch_slot_t expect_slot(input logic [31:0] word,
                                                 input int        first);
    dispatch_slot_t s;
    s.valid  = 1'b1;
    s.rn     = field[first][PREG_W-1:0];
    s.opcode = word[6:0];  // passed straight through
    s.imm12  = word[31:20];
    s.src_1  = expect_operand(field[first+1], field[first+2]);
    s.src_2  = expect_operand(field[first+3], field[first+4]);
    return s;
  endfunction

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // ******************************
  // dispatch side
  // ******************************
  always @(negedge global_bus) begin : dispatch_monitor
    if (stall_on) begin
      lfsr           = lfsr_next(lfsr);
      dispatch_ready = lfsr[0];
    end else begin
      dispatch_ready = 1'b1;
    end
    #SETTLE;
    if (dispatch_valid === 1'b1 && dispatch_ready) begin
      if (expected_q.size() < ISSUE_WIDTH) begin
        abort_run("dispatch transfer seen with no bundle outstanding");
      end else begin
        check_slot("dispatch[0]", dispatch[0], expected_q.pop_front());
        check_slot("dispatch[1]", dispatch[1], expected_q.pop_front());
        idle_cycles = 0;
      end
    end else if (expected_q.size() != 0) begin
      idle_cycles++;
      if (idle_cycles >= TIMEOUT) begin
        abort_run("accepted bundle never left the dispatch port");
      end
    end
  end

  // ******************************
  // stimulus steps
  // ******************************
  task automatic send_bundle();
    int waited;
    waited       = 0;
    bundle_spec  = field[0][0];
    bundle_in[0] = field[1];
    bundle_in[1] = field[2];
    bundle_valid = 1'b1;
    #SETTLE;
    while (!bundle_ready) begin
      @(negedge global_bus);
      #SETTLE;
      waited++;
      if (waited >= TIMEOUT) begin
        abort_run("bundle_ready did not rise for a pending bundle");
      end
    end
    expected_q.push_back(expect_slot(field[1], 3));
    expected_q.push_back(expect_slot(field[2], 8));
    @(negedge global_bus);
    bundle_valid = 1'b0;
  endtask

  task automatic apply_writeback();
    int port;
    port               = field[0][0];
    wb[port].arn       = field[1][ARCH_W-1:0];
    wb[port].rrn       = field[2][PREG_W-1:0];
    wb[port].result    = field[3];
    wb[port].valid     = 1'b1;
    @(negedge global_bus);
    wb[port].valid     = 1'b0;
  endtask

  task automatic pulse_control(input logic flush);
    if (flush) begin
      spec_flush = 1'b1;
    end else begin
      spec_clear = 1'b1;
    end
    @(negedge global_bus);
    spec_flush = 1'b0;
    spec_clear = 1'b0;
  endtask

  task automatic set_stall();
    #SETTLE;
    stall_on = field[0][0];
    @(negedge global_bus);
  endtask

  task automatic drain_dispatch();
    int waited;
    waited = 0;
    while (expected_q.size() != 0) begin
      @(negedge global_bus);
      waited++;
      if (waited >= TIMEOUT) begin
        abort_run("dispatch queue did not drain");
      end
    end
  endtask

  task automatic expect_blocked();
    for (int n = 0; n < int'(field[0]); n++) begin
      #SETTLE;
      check_flag("bundle_ready", bundle_ready, 1'b0);
      @(negedge global_bus);
    end
  endtask

  initial begin : run_steps
    int          fd;
    int          got;
    logic [7:0]  cmd;
    string       line;
    global_bus     = 1'b0;
    rst_n          = 1'b0;
    bundle_in[0]   = '0;
    bundle_in[1]   = '0;
    bundle_valid   = 1'b0;
    bundle_spec    = 1'b0;
    wb[0]          = '0;
    wb[1]          = '0;
    spec_clear     = 1'b0;
    spec_flush     = 1'b0;
    dispatch_ready = 1'b1;
    stall_on       = 1'b0;
    lfsr           = 32'd65548;
    idle_cycles    = 0;

    repeat (5) @(posedge global_bus);
    @(negedge global_bus);
    rst_n = 1'b1;
    #SETTLE;
    check_flag("dispatch_valid", dispatch_valid, 1'b0);
    @(negedge global_bus);

    fd = $fopen("verification/rename_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the stimulus file");
    end
    while ($fgets(line, fd) != 0) begin
      cmd = (line.len() > 0) ? line.getc(0) : "#";
      case (cmd)
        "B": begin
          got = $sscanf(line, "B %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        field[0], field[1], field[2], field[3], field[4], field[5],
                        field[6], field[7], field[8], field[9], field[10], field[11],
                        field[12]);
          if (got != 13) begin
            abort_run("bundle line in the stimulus file is malformed");
          end
          send_bundle();
        end
        "W": begin
          got = $sscanf(line, "W %h %h %h %h", field[0], field[1], field[2], field[3]);
          if (got != 4) begin
            abort_run("write-back line in the stimulus file is malformed");
          end
          apply_writeback();
        end
        "S": begin
          got = $sscanf(line, "S %h", field[0]);
          if (got != 1) begin
            abort_run("stall line in the stimulus file is malformed");
          end
          set_stall();
        end
        "R": begin
          got = $sscanf(line, "R %h", field[0]);
          if (got != 1) begin
            abort_run("blocked line in the stimulus file is malformed");
          end
          expect_blocked();
        end
        "C": pulse_control(1'b0);
        "F": pulse_control(1'b1);
        "D": drain_dispatch();
        "#", "\n", "\r", " ": ;  // comment or blank line
        default: abort_run("unknown command in the stimulus file");
      endcase
    end
    $fclose(fd);

    drain_dispatch();
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* verification/rename_stimulus.txt */
# B spec word0 word1, then per slot: rn rdy1 src1 rdy2 src2 (src = value if rdy, else tag)
# W port arn rrn result | C clear | F flush | S stall | D drain | R cycles with bundle_ready low
B 0 00108293 00310333 20 1 0 1 0 21 1 0 1 0
B 0 006283b3 00428413 22 0 20 0 21 23 0 20 1 0
W 0 0 20 11111111
B 0 00028493 00030513 24 0 20 1 0 25 0 21 1 0
W 0 5 20 11111111
W 1 6 21 22222222
B 0 006285b3 00558633 26 1 11111111 1 22222222 27 0 26 1 11111111
B 1 00700293 00828313 28 1 0 1 0 29 0 28 1 0
F
B 0 006286b3 00028713 2a 1 11111111 1 22222222 2b 1 11111111 1 0
B 1 00300793 00400813 2c 1 0 1 0 2d 1 0 1 0
C
F
B 0 010788b3 00078913 2e 0 2c 0 2d 2f 0 2c 1 0
S 1
B 0 00128993 00230a13 30 1 11111111 1 0 31 1 22222222 1 0
B 0 00628ab3 006a8b33 32 1 11111111 1 22222222 33 0 32 1 22222222
B 0 00098b93 000a0c13 34 0 30 1 0 35 0 31 1 0
B 0 00208cb3 0021a023 36 1 0 1 0 0 1 0 1 0
S 0
D
B 0 00100d93 00200e13 37 1 0 1 0 38 1 0 1 0
B 0 00100d93 00200e13 39 1 0 1 0 3a 1 0 1 0
B 0 00100d93 00200e13 3b 1 0 1 0 3c 1 0 1 0
B 0 00100d93 00200e13 3d 1 0 1 0 3e 1 0 1 0
B 0 00100d93 00200e13 3f 1 0 1 0 20 1 0 1 0
B 0 00100d93 00200e13 21 1 0 1 0 28 1 0 1 0
D
R 5
W 1 13 30 33333333
B 0 00098e93 000b8f13 29 1 33333333 1 0 30 0 34 1 0
D

/* filelist.f */
source/rename_pkg.sv
source/bundle_decoder.sv
source/operand_lane.sv
source/register_file.sv
source/dispatch_merger.sv
source/rename_unit.sv
verification/rename_unit_tb.sv
